/* project.f */
+incdir+verilog
verilog/dmi_pkg.sv
verilog/dmi_ingress.sv
verilog/dmi_req_fifo.sv
verilog/dm_regs.sv
verilog/dmi_top.sv
test/dmi_top_properties.sv
test/tb_dmi_top.sv

/* test/dmi_top_properties.sv */
`timescale 1ns/10ps

module dmi_top_properties (
  input logic                 clk_i,
  input logic                 ndmreset_n,
  input logic                 req_ready_i,
  input logic                 resp_valid_i,
  input logic                 resp_ready_i,
  input dmi_pkg::dmi_resp_t   resp_i,
  input logic                 dm_rst_i,
  input logic                 dmactive_i
);

  int err_cnt = 0; // failures seen so far

  // ------------------------------------------------------------
  // response handshake
  // ------------------------------------------------------------
  property p_resp_hold;
    @(posedge clk_i) disable iff (!ndmreset_n)
      resp_valid_i && !resp_ready_i |=> resp_valid_i && $stable(resp_i);
  endproperty

  a_resp_hold: assert property (p_resp_hold) else begin
    $error("response valid or payload changed before ready");
    err_cnt++;
  end

  // request side closed while reset is held
  property p_req_ready_reset;
    @(posedge clk_i) !ndmreset_n |-> !req_ready_i;
  endproperty

  a_req_ready_reset: assert property (p_req_ready_reset) else begin
    $error("request ready high during reset");
    err_cnt++;
  end

  property p_rst_needs_active;
    @(posedge clk_i) disable iff (!ndmreset_n) !dmactive_i |-> !dm_rst_i;
  endproperty

  a_rst_needs_active: assert property (p_rst_needs_active) else begin
    $error("dm_rst_o high with dmactive low");
    err_cnt++;
  end

endmodule

/* test/tb_dmi_top.sv */
`timescale 1ns/10ps
`include "dmi_params.svh"

module tb_dmi_top;
  import dmi_pkg::*;

  localparam int CLK_PERIOD      = 100;
  localparam int DRIVE_DELAY     = 10;
  localparam int NUM_RANDOM      = 300;
  localparam int WATCHDOG_CYCLES = `DMI_DEL_CYCLES + NUM_RANDOM * 12;

  logic clk_i, ndmreset_n, dmi_req_valid_i, dmi_req_ready_o;
  logic dmi_resp_valid_o, dmi_resp_ready_i, dm_rst_o;
  dmi_req_t             dmi_req_i;
  dmi_resp_t            dmi_resp_o, exp_resp;
  logic [`NR_HARTS-1:0] debug_req_o;

  // reference model
  logic [`DMI_DATA_W-1:0] m_data0, m_data1;
  logic                   m_dmactive, m_ndmreset, m_haltreq;
  logic [1:0]             m_hartsel;
  dmi_resp_t              exp_q[$];

  int   seed, stall_left;
  int   edge_cnt = 0;
  int   resp_cnt = 0;
  logic stall_en, saw_backpressure;

  dmi_top uut (.*);

  bind dmi_top dmi_top_properties u_props (
    .clk_i(clk_i), .ndmreset_n(ndmreset_n), .req_ready_i(dmi_req_ready_o),
    .resp_valid_i(dmi_resp_valid_o), .resp_ready_i(dmi_resp_ready_i), .resp_i(dmi_resp_o),
    .dm_rst_i(dm_rst_o), .dmactive_i(i_dm_regs.dmactive_q)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    if (ndmreset_n) edge_cnt <= edge_cnt + 1; // edges since reset release
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("ERROR: the run hung and the watchdog expired at %0t", $time);
    $display("TEST FAILED");
    $fatal(1, "watchdog");
  end

  task automatic value_error(input string msg);
    $display("FAIL t=%0t %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1, "mismatch");
  endtask

  function automatic logic [`DMI_DATA_W-1:0] model_read(input logic [`DMI_ADDR_W-1:0] addr);
    case (addr)
      `ADDR_DATA0:     return m_data0;
      `ADDR_DATA1:     return m_data1;
      `ADDR_DMCONTROL: return (32'(m_haltreq) << 31) | (32'(m_hartsel) << 16) |
                              (32'(m_ndmreset) << 1) | 32'(m_dmactive);
      `ADDR_DMSTATUS:  return (32'd1 << 7) | 32'(`DM_VERSION); // authenticated, version
      default:         return '0;
    endcase
  endfunction

  task automatic model_apply(input dmi_req_t req);
    dmi_resp_t r;
    r.resp = SUCCESS;
    r.data = '0;
    if (req.op == READ) r.data = model_read(req.addr);
    if (req.op == RSVD) r.resp = FAILED;
    if (req.op == WRITE) begin
      case (req.addr)
        `ADDR_DATA0: m_data0 = req.data;
        `ADDR_DATA1: m_data1 = req.data;
        `ADDR_DMCONTROL: begin
          if (m_dmactive) begin
            m_ndmreset = req.data[1];
            m_hartsel  = req.data[17:16];
            m_haltreq  = req.data[31];
          end
          m_dmactive = req.data[0];
        end
        default: ;
      endcase
    end
    exp_q.push_back(r);
  endtask

  // called at a falling edge with all commands executed
  task automatic check_outputs();
    logic [`NR_HARTS-1:0] exp_dbg;
    for (int h = 0; h < `NR_HARTS; h++) begin
      exp_dbg[h] = m_haltreq && m_dmactive && m_hartsel == h && edge_cnt >= `DMI_DEL_CYCLES;
    end
    assert (dm_rst_o === (m_ndmreset & m_dmactive))
      else value_error($sformatf("dm_rst_o expected %b got %b", m_ndmreset & m_dmactive, dm_rst_o));
    assert (debug_req_o === exp_dbg)
      else value_error($sformatf("debug_req_o expected %b got %b", exp_dbg, debug_req_o));
  endtask

  task automatic send_req(input logic [6:0] addr, input dmi_op_e op, input logic [31:0] data);
    dmi_req_i.addr  = addr;
    dmi_req_i.op    = op;
    dmi_req_i.data  = data;
    dmi_req_valid_i = 1'b1;
    @(negedge clk_i);
    while (!dmi_req_ready_o) @(negedge clk_i);
    model_apply(dmi_req_i); // transfer on the coming edge
    @(posedge clk_i);
    #DRIVE_DELAY;
    dmi_req_valid_i = 1'b0;
  endtask

  task automatic drain_and_check();
    while (exp_q.size() != 0) @(negedge clk_i);
    @(negedge clk_i);
    check_outputs();
    @(posedge clk_i);
    #DRIVE_DELAY;
  endtask

  // ------------------------------------------------------------
  // response ready with random stalls, response checking
  // ------------------------------------------------------------
  initial begin
    stall_left = 0;
    forever begin
      @(posedge clk_i);
      #DRIVE_DELAY;
      dmi_resp_ready_i = !(stall_en && stall_left > 0);
      if (stall_left > 0) stall_left--;
      else if (stall_en && ($random(seed) & 3) == 0) stall_left = $random(seed) & 15;
    end
  end

  always @(negedge clk_i) begin
    if (ndmreset_n && dmi_resp_valid_o && dmi_resp_ready_i) begin
      assert (exp_q.size() != 0) else value_error("response with no request outstanding");
      exp_resp = exp_q.pop_front();
      resp_cnt++;
      assert (dmi_resp_o === exp_resp) else value_error($sformatf(
        "response %0d expected %h got %h", resp_cnt, exp_resp, dmi_resp_o));
    end
    if (dmi_resp_valid_o && !dmi_resp_ready_i && !dmi_req_ready_o) saw_backpressure = 1'b1;
    assert (edge_cnt >= `DMI_DEL_CYCLES || debug_req_o === '0)
      else value_error($sformatf("debug_req_o %b inside boot window", debug_req_o));
    assert (uut.u_props.err_cnt == 0) else value_error("bound handshake or reset property failed");
  end

  initial begin
    logic [31:0] d0, d1, r;
    logic [6:0]  addr;
    seed = 51300;
    ndmreset_n = 1'b1;
    dmi_req_valid_i = 1'b0;
    dmi_req_i = '0;
    dmi_resp_ready_i = 1'b1;
    stall_en = 1'b0;
    saw_backpressure = 1'b0;
    {m_data0, m_data1, m_dmactive, m_ndmreset, m_haltreq, m_hartsel} = '0;
    #1 ndmreset_n = 1'b0;
    repeat (4) @(posedge clk_i);
    #DRIVE_DELAY;
    ndmreset_n = 1'b1;

    send_req(`ADDR_DMCONTROL, WRITE, 32'h8000_0002); // inactive DM ignores this
    send_req(`ADDR_DMCONTROL, READ, '0);
    drain_and_check();
    send_req(`ADDR_DMCONTROL, WRITE, 32'h1);
    send_req(`ADDR_DMCONTROL, WRITE, 32'h3);
    drain_and_check();
    send_req(`ADDR_DMCONTROL, WRITE, 32'h1);
    drain_and_check();

    // haltreq on hart 2 inside the boot window
    send_req(`ADDR_DMCONTROL, WRITE, 32'h8002_0001);
    send_req(`ADDR_DMCONTROL, READ, '0);
    drain_and_check();
    while (edge_cnt < `DMI_DEL_CYCLES - 1) @(negedge clk_i);
    check_outputs();
    while (edge_cnt < `DMI_DEL_CYCLES) @(negedge clk_i);
    check_outputs();
    @(posedge clk_i);
    #DRIVE_DELAY;
    send_req(`ADDR_DMCONTROL, WRITE, 32'h8001_0001);
    drain_and_check();

    d0 = $random(seed);
    d1 = $random(seed);
    send_req(`ADDR_DATA0, WRITE, d0);
    send_req(`ADDR_DATA1, WRITE, d1);
    send_req(`ADDR_DATA0, READ, '0);
    send_req(`ADDR_DATA1, READ, '0);
    send_req(`ADDR_DMSTATUS, READ, '0);
    send_req(7'h00, READ, '0);
    send_req(7'h7f, READ, '0);
    send_req(7'h12, READ, '0);
    send_req(`ADDR_DATA0, RSVD, ~d0);
    send_req(`ADDR_DMCONTROL, RSVD, '0);
    send_req(`ADDR_DATA0, READ, '0);
    send_req(`ADDR_DMCONTROL, READ, '0);
    drain_and_check();

    // ------------------------------------------------------------
    // random traffic under response stalls
    // ------------------------------------------------------------
    stall_en = 1'b1;
    repeat (NUM_RANDOM) begin
      r = $random(seed);
      case (r[2:0])
        3'd0:    addr = `ADDR_DATA0;
        3'd1:    addr = `ADDR_DATA1;
        3'd2:    addr = `ADDR_DMCONTROL;
        3'd3:    addr = `ADDR_DMSTATUS;
        default: addr = r[9:3];
      endcase
      send_req(addr, dmi_op_e'(r[11:10]), $random(seed));
    end
    drain_and_check();
    stall_en = 1'b0;

    if (saw_backpressure && uut.u_props.err_cnt == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("ERROR: request ready never dropped under a stalled response");
      $display("TEST FAILED");
      $fatal(1, "no back-pressure seen");
    end
  end

endmodule

/* verilog/dm_regs.sv */
`timescale 1ns/10ps
`include "dmi_params.svh"

module dm_regs (
  input  logic                 clk_i,
  input  logic                 ndmreset_n,
  // commands from the FIFO
  input  logic                 cmd_valid_i,
  output logic                 cmd_ready_o,
  input  dmi_pkg::dm_cmd_t     cmd_i,
  // DMI response
  output logic                 resp_valid_o,
  input  logic                 resp_ready_i,
  output dmi_pkg::dmi_resp_t   resp_o,
  // debug module outputs
  output logic                 dm_rst_o,
  output logic [`NR_HARTS-1:0] debug_req_o
);
  import dmi_pkg::*;

  localparam int unsigned DEL_W = $clog2(`DMI_DEL_CYCLES + 1);

  dm_state_e              state_q;
  dmi_resp_t              resp_q, resp_d;
  logic                   accept;

  logic [`DMI_DATA_W-1:0] data0_q, data1_q;
  logic                   dmactive_q, ndmreset_q, haltreq_q;
  logic [1:0]             hartsel_q;
  logic [DEL_W-1:0]       del_cnt_q;

  logic [`DMI_DATA_W-1:0] dmcontrol, dmstatus, rdata;
  logic [`NR_HARTS-1:0]   hart_sel_dec;

  assign cmd_ready_o  = (state_q == ST_IDLE);
  assign accept       = cmd_valid_i & cmd_ready_o;
  assign resp_valid_o = (state_q == ST_RESP);
  assign resp_o       = resp_q;

  // ------------------------------------------------------------
  // register views and read mux
  // ------------------------------------------------------------
  assign dmcontrol = {haltreq_q, 13'b0, hartsel_q, 14'b0, ndmreset_q, dmactive_q};
  assign dmstatus  = {24'b0, 1'b1, 3'b0, 4'(`DM_VERSION)}; // authenticated always set

  always_comb begin
    case (cmd_i.reg_sel)
      REG_DATA0:     rdata = data0_q;
      REG_DATA1:     rdata = data1_q;
      REG_DMCONTROL: rdata = dmcontrol;
      REG_DMSTATUS:  rdata = dmstatus;
      default:       rdata = '0;
    endcase
  end

  always_comb begin
    resp_d.resp = SUCCESS;
    resp_d.data = '0;
    case (cmd_i.op)
      READ:    resp_d.data = rdata;
      RSVD:    resp_d.resp = FAILED;
      default: ; // NOP and WRITE answer zero
    endcase
  end

  // ------------------------------------------------------------
  // FSM and register writes
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      state_q    <= ST_IDLE;
      data0_q    <= '0;
      data1_q    <= '0;
      dmactive_q <= 1'b0;
      ndmreset_q <= 1'b0;
      haltreq_q  <= 1'b0;
      hartsel_q  <= '0;
    end else begin
      case (state_q)
        ST_IDLE: if (accept) state_q <= ST_RESP;
        ST_RESP: if (resp_ready_i) state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase

      if (accept && cmd_i.op == WRITE) begin
        case (cmd_i.reg_sel)
          REG_DATA0: data0_q <= cmd_i.data;
          REG_DATA1: data1_q <= cmd_i.data;
          REG_DMCONTROL: begin
            dmactive_q <= cmd_i.data[0];
            if (dmactive_q) begin // inactive DM only sees dmactive
              ndmreset_q <= cmd_i.data[1];
              hartsel_q  <= cmd_i.data[17:16];
              haltreq_q  <= cmd_i.data[31];
            end
          end
          default: ; // DMSTATUS is read-only
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      resp_q <= resp_d;
    end
  end

  // ------------------------------------------------------------
  // boot delay before halt requests reach the harts
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      del_cnt_q <= DEL_W'(`DMI_DEL_CYCLES);
    end else if (del_cnt_q != '0) begin
      del_cnt_q <= del_cnt_q - 1'b1;
    end
  end

  assign hart_sel_dec = `NR_HARTS'(1) << hartsel_q;
  assign debug_req_o  = (haltreq_q && dmactive_q && del_cnt_q == '0) ? hart_sel_dec : '0;
  assign dm_rst_o     = ndmreset_q & dmactive_q;

endmodule

/* verilog/dmi_ingress.sv */
`timescale 1ns/10ps
`include "dmi_params.svh"

module dmi_ingress (
  input  logic              clk_i,
  input  logic              ndmreset_n,
  // external DMI request
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  dmi_pkg::dmi_req_t req_i,
  // decoded command towards the FIFO
  output logic              cmd_valid_o,
  input  logic              cmd_ready_i,
  output dmi_pkg::dm_cmd_t  cmd_o
);
  import dmi_pkg::*;

  logic    valid_q;
  dm_cmd_t cmd_q;
  dm_cmd_t cmd_d;

  // ------------------------------------------------------------
  // address decode
  // ------------------------------------------------------------
  always_comb begin
    cmd_d.op   = req_i.op;
    cmd_d.data = req_i.data;
    case (req_i.addr)
      `ADDR_DATA0:     cmd_d.reg_sel = REG_DATA0;
      `ADDR_DATA1:     cmd_d.reg_sel = REG_DATA1;
      `ADDR_DMCONTROL: cmd_d.reg_sel = REG_DMCONTROL;
      `ADDR_DMSTATUS:  cmd_d.reg_sel = REG_DMSTATUS;
      default:         cmd_d.reg_sel = REG_NONE; // unmapped
    endcase
  end

  // empty, or the held entry leaves this cycle
  // closed while reset is held
  assign req_ready_o = ndmreset_n & (~valid_q | cmd_ready_i);

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      valid_q <= 1'b0;
    end else if (req_ready_o) begin
      valid_q <= req_valid_i;
    end
  end

  // payload only moves on a transfer
  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      cmd_q <= cmd_d;
    end
  end

  assign cmd_valid_o = valid_q;
  assign cmd_o       = cmd_q;

endmodule

/* verilog/dmi_params.svh */
`ifndef DMI_PARAMS_SVH
`define DMI_PARAMS_SVH

// ------------------------------------------------------------
// DMI widths and buffering
// ------------------------------------------------------------
`define DMI_ADDR_W      7
`define DMI_DATA_W      32
`define DMI_FIFO_DEPTH  4

// hart count and boot window
`define NR_HARTS        4
`define DMI_DEL_CYCLES  500

// ------------------------------------------------------------
// debug register map
// ------------------------------------------------------------
`define ADDR_DATA0      7'h04
`define ADDR_DATA1      7'h05
`define ADDR_DMCONTROL  7'h10
`define ADDR_DMSTATUS   7'h11

`define DM_VERSION      2 // debug spec 0.13

`endif

/* verilog/dmi_pkg.sv */
`include "dmi_params.svh"

package dmi_pkg;

  // ------------------------------------------------------------
  // encodings seen on the DMI port
  // ------------------------------------------------------------
  typedef enum logic [1:0] {
    NOP   = 2'h0,
    READ  = 2'h1,
    WRITE = 2'h2,
    RSVD  = 2'h3
  } dmi_op_e;

  typedef enum logic [1:0] {
    SUCCESS   = 2'h0,
    RSVD_CODE = 2'h1,
    FAILED    = 2'h2,
    BUSY      = 2'h3
  } dmi_status_e;

  typedef struct packed {
    logic [`DMI_ADDR_W-1:0] addr;
    dmi_op_e                op;
    logic [`DMI_DATA_W-1:0] data;
  } dmi_req_t;

  typedef struct packed {
    dmi_status_e            resp;
    logic [`DMI_DATA_W-1:0] data;
  } dmi_resp_t;

  // ------------------------------------------------------------
  // internal command after address decode
  // ------------------------------------------------------------
  typedef enum logic [2:0] {
    REG_DATA0,
    REG_DATA1,
    REG_DMCONTROL,
    REG_DMSTATUS,
    REG_NONE
  } dm_reg_e;

  typedef struct packed {
    dm_reg_e                reg_sel;
    dmi_op_e                op;
    logic [`DMI_DATA_W-1:0] data;
  } dm_cmd_t;

  typedef enum logic {
    ST_IDLE,
    ST_RESP
  } dm_state_e;

endpackage

/* verilog/dmi_req_fifo.sv */
`timescale 1ns/10ps
`include "dmi_params.svh"

module dmi_req_fifo #(
  parameter int unsigned DEPTH = `DMI_FIFO_DEPTH // power of two, 2 or more
) (
  input  logic             clk_i,
  input  logic             ndmreset_n,
  input  logic             wr_valid_i,
  output logic             wr_ready_o,
  input  dmi_pkg::dm_cmd_t wr_data_i,
  output logic             rd_valid_o,
  input  logic             rd_ready_i,
  output dmi_pkg::dm_cmd_t rd_data_o
);
  import dmi_pkg::*;

  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = PTR_W + 1;

  dm_cmd_t          mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full, wr_en, rd_en;

  assign full       = (count_q == CNT_W'(DEPTH));
  assign rd_valid_o = (count_q != '0);
  assign wr_ready_o = ~full | rd_ready_i; // full only takes a write alongside a read
  assign wr_en      = wr_valid_i & wr_ready_o;
  assign rd_en      = rd_valid_o & rd_ready_i;
  assign rd_data_o  = mem[rd_ptr_q];

  // ------------------------------------------------------------
  // pointers and occupancy
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) wr_ptr_q <= wr_ptr_q + 1'b1; // wraps at DEPTH
      if (rd_en) rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem[wr_ptr_q] <= wr_data_i;
    end
  end

endmodule

/* verilog/dmi_top.sv */
`timescale 1ns/10ps
`include "dmi_params.svh"

module dmi_top (
  input  logic                 clk_i,
  input  logic                 ndmreset_n,
  // DMI request
  input  logic                 dmi_req_valid_i,
  output logic                 dmi_req_ready_o,
  input  dmi_pkg::dmi_req_t    dmi_req_i,
  // DMI response
  output logic                 dmi_resp_valid_o,
  input  logic                 dmi_resp_ready_i,
  output dmi_pkg::dmi_resp_t   dmi_resp_o,
  // to the harts
  output logic                 dm_rst_o,
  output logic [`NR_HARTS-1:0] debug_req_o
);
  import dmi_pkg::*;

  logic    ing_valid, ing_ready;
  dm_cmd_t ing_cmd;
  logic    fifo_valid, fifo_ready;
  dm_cmd_t fifo_cmd;

  // ------------------------------------------------------------
  // ingress -> FIFO -> register block
  // ------------------------------------------------------------
  dmi_ingress i_dmi_ingress (
    .clk_i       ( clk_i           ),
    .ndmreset_n  ( ndmreset_n      ),
    .req_valid_i ( dmi_req_valid_i ),
    .req_ready_o ( dmi_req_ready_o ),
    .req_i       ( dmi_req_i       ),
    .cmd_valid_o ( ing_valid       ),
    .cmd_ready_i ( ing_ready       ),
    .cmd_o       ( ing_cmd         )
  );

  dmi_req_fifo #(
    .DEPTH ( `DMI_FIFO_DEPTH )
  ) i_dmi_req_fifo (
    .clk_i      ( clk_i      ),
    .ndmreset_n ( ndmreset_n ),
    .wr_valid_i ( ing_valid  ),
    .wr_ready_o ( ing_ready  ),
    .wr_data_i  ( ing_cmd    ),
    .rd_valid_o ( fifo_valid ),
    .rd_ready_i ( fifo_ready ),
    .rd_data_o  ( fifo_cmd   )
  );

  dm_regs i_dm_regs (
    .clk_i        ( clk_i            ),
    .ndmreset_n   ( ndmreset_n       ),
    .cmd_valid_i  ( fifo_valid       ),
    .cmd_ready_o  ( fifo_ready       ),
    .cmd_i        ( fifo_cmd         ),
    .resp_valid_o ( dmi_resp_valid_o ),
    .resp_ready_i ( dmi_resp_ready_i ),
    .resp_o       ( dmi_resp_o       ),
    .dm_rst_o     ( dm_rst_o         ),
    .debug_req_o  ( debug_req_o      ) // gated by boot delay
  );

endmodule
